//--- hdl/slice_pkg.sv
package slice_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int WORD_BITS = 32;
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int VPN_BITS = WORD_BITS - PAGE_OFFSET_BITS;
    localparam int REG_COUNT = 8;
    localparam int TLB_ENTRIES = 8;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [VPN_BITS-1:0] vpn_t;
    typedef logic [VPN_BITS-1:0] pfn_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
    typedef logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_t;

    //////////////////////////////////////////////////////////////////////
    // Codes
    //////////////////////////////////////////////////////////////////////

    // ALU_SHL takes its shift amount from op_b[4:0]
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHL = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        FAULT_NONE       = 2'd0,
        FAULT_TLB_MISS   = 2'd1,
        FAULT_WRITE_PROT = 2'd2
    } fault_e;

endpackage

//--- hdl/stage_ifs.sv
`timescale 1ns/1ps

// RrAg to MEM
interface ag_if;
    import slice_pkg::*;

    logic    valid;
    word_t   eip;
    alu_op_e aluk;
    word_t   op_a;
    word_t   op_b;
    word_t   lin_addr;
    logic    mem_wr;

    modport src (output valid, eip, aluk, op_a, op_b, lin_addr, mem_wr);
    modport dst (input valid, eip, aluk, op_a, op_b, lin_addr, mem_wr);

endinterface

// MEM to queue, and queue head to EX
interface xlat_if;
    import slice_pkg::*;

    logic    valid;
    word_t   eip;
    alu_op_e aluk;
    word_t   op_a;
    word_t   op_b;
    word_t   phys_addr;
    fault_e  fault;

    modport src (output valid, eip, aluk, op_a, op_b, phys_addr, fault);
    modport dst (input valid, eip, aluk, op_a, op_b, phys_addr, fault);

endinterface

//--- hdl/rrag_stage.sv
`timescale 1ns/1ps

module rrag_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rf_wr,
    input  slice_pkg::reg_idx_t rf_wr_addr,
    input  slice_pkg::word_t    rf_wr_data,
    input  logic                in_valid,
    input  slice_pkg::word_t    in_eip,
    input  slice_pkg::alu_op_e  in_aluk,
    input  slice_pkg::reg_idx_t in_base_reg,
    input  slice_pkg::reg_idx_t in_src_reg,
    input  slice_pkg::word_t    in_disp,
    input  logic                in_mem_wr,
    ag_if.src                   ag
);
    import slice_pkg::*;

    word_t rf [REG_COUNT];
    word_t base_val;
    word_t src_val;

    // Loaded only while nothing is in flight, so no bypass
    always_ff @(posedge clk) begin
        if (rf_wr) begin
            rf[rf_wr_addr] <= rf_wr_data;
        end
    end

    assign base_val = rf[in_base_reg];
    assign src_val = rf[in_src_reg];

    //////////////////////////////////////////////////////////////////////
    // RrAg to MEM register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ag.valid <= 1'b0;
        end else begin
            ag.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            ag.eip <= in_eip;
            ag.aluk <= in_aluk;
            ag.op_a <= src_val;
            ag.op_b <= in_disp;
            // Linear address is base plus displacement, no segment base
            ag.lin_addr <= base_val + in_disp;
            ag.mem_wr <= in_mem_wr;
        end
    end

endmodule

//--- hdl/mem_tlb_stage.sv
`timescale 1ns/1ps

module mem_tlb_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tlb_wr,
    input  slice_pkg::tlb_idx_t tlb_wr_idx,
    input  slice_pkg::vpn_t     tlb_wr_vp,
    input  slice_pkg::pfn_t     tlb_wr_pf,
    input  logic                tlb_wr_valid,
    input  logic                tlb_wr_rw,
    ag_if.dst                   ag,
    xlat_if.src                 mem_q
);
    import slice_pkg::*;

    vpn_t                   tlb_vp [TLB_ENTRIES];
    pfn_t                   tlb_pf [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] tlb_valid;
    logic [TLB_ENTRIES-1:0] tlb_rw;

    vpn_t     lookup_vpn;
    logic     hit;
    tlb_idx_t hit_idx;
    word_t    phys_addr;
    fault_e   fault;

    //////////////////////////////////////////////////////////////////////
    // TLB table
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tlb_valid <= '0;
        end else if (tlb_wr) begin
            tlb_valid[tlb_wr_idx] <= tlb_wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr) begin
            tlb_vp[tlb_wr_idx] <= tlb_wr_vp;
            tlb_pf[tlb_wr_idx] <= tlb_wr_pf;
            tlb_rw[tlb_wr_idx] <= tlb_wr_rw;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    assign lookup_vpn = ag.lin_addr[WORD_BITS-1:PAGE_OFFSET_BITS];

    // Scan downward so the lowest matching entry is the one kept
    always_comb begin
        hit = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (tlb_valid[i] && (tlb_vp[i] == lookup_vpn)) begin
                hit = 1'b1;
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    always_comb begin
        if (!hit) begin
            phys_addr = '0;
            fault = FAULT_TLB_MISS;
        end else begin
            phys_addr = {tlb_pf[hit_idx], ag.lin_addr[PAGE_OFFSET_BITS-1:0]};
            if (ag.mem_wr && !tlb_rw[hit_idx]) begin
                fault = FAULT_WRITE_PROT;
            end else begin
                fault = FAULT_NONE;
            end
        end
    end

    // Valid here is a push into the queue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_q.valid <= 1'b0;
        end else begin
            mem_q.valid <= ag.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ag.valid) begin
            mem_q.eip <= ag.eip;
            mem_q.aluk <= ag.aluk;
            mem_q.op_a <= ag.op_a;
            mem_q.op_b <= ag.op_b;
            mem_q.phys_addr <= phys_addr;
            mem_q.fault <= fault;
        end
    end

endmodule

//--- hdl/queued_latch.sv
`timescale 1ns/1ps

module queued_latch #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic clk,
    input  logic rst_n,
    xlat_if.dst  mem_q,
    xlat_if.src  q_ex,
    input  logic pop,
    output logic in_credit
);
    import slice_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    word_t   eip_q [QUEUE_DEPTH];
    alu_op_e aluk_q [QUEUE_DEPTH];
    word_t   op_a_q [QUEUE_DEPTH];
    word_t   op_b_q [QUEUE_DEPTH];
    word_t   phys_q [QUEUE_DEPTH];
    fault_e  fault_q [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign do_pop = pop && (count != '0);

    // Storage, space is guaranteed by the input credits
    always_ff @(posedge clk) begin
        if (mem_q.valid) begin
            eip_q[wr_ptr] <= mem_q.eip;
            aluk_q[wr_ptr] <= mem_q.aluk;
            op_a_q[wr_ptr] <= mem_q.op_a;
            op_b_q[wr_ptr] <= mem_q.op_b;
            phys_q[wr_ptr] <= mem_q.phys_addr;
            fault_q[wr_ptr] <= mem_q.fault;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end else begin
            if (mem_q.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({mem_q.valid, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back to the source per pop
            in_credit <= do_pop;
        end
    end

    // Head entry
    assign q_ex.valid = (count != '0);
    assign q_ex.eip = eip_q[rd_ptr];
    assign q_ex.aluk = aluk_q[rd_ptr];
    assign q_ex.op_a = op_a_q[rd_ptr];
    assign q_ex.op_b = op_b_q[rd_ptr];
    assign q_ex.phys_addr = phys_q[rd_ptr];
    assign q_ex.fault = fault_q[rd_ptr];

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
    parameter int OUT_CREDITS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    xlat_if.dst               q_ex,
    output logic              pop,
    input  logic              out_credit,
    output logic              out_valid,
    output slice_pkg::word_t  out_eip,
    output slice_pkg::word_t  out_result,
    output slice_pkg::word_t  out_phys_addr,
    output slice_pkg::fault_e out_fault
);
    import slice_pkg::*;

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    word_t             alu_out;

    //////////////////////////////////////////////////////////////////////
    // Output credits
    //////////////////////////////////////////////////////////////////////

    assign pop = q_ex.valid && (credits != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CRED_W'(OUT_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (q_ex.aluk)
            ALU_ADD: alu_out = q_ex.op_a + q_ex.op_b;
            ALU_SUB: alu_out = q_ex.op_a - q_ex.op_b;
            ALU_AND: alu_out = q_ex.op_a & q_ex.op_b;
            ALU_OR:  alu_out = q_ex.op_a | q_ex.op_b;
            ALU_XOR: alu_out = q_ex.op_a ^ q_ex.op_b;
            ALU_SHL: alu_out = q_ex.op_a << q_ex.op_b[4:0];
            default: alu_out = '0;
        endcase
    end

    // Result register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_eip <= q_ex.eip;
            // Faulting ops report no result
            out_result <= (q_ex.fault == FAULT_NONE) ? alu_out : '0;
            out_phys_addr <= q_ex.phys_addr;
            out_fault <= q_ex.fault;
        end
    end

endmodule

//--- hdl/core_slice_top.sv
`timescale 1ns/1ps

module core_slice_top #(
    parameter int QUEUE_DEPTH = 8,
    parameter int OUT_CREDITS = 4
) (
    input  logic                clk,
    input  logic                rst_n,

    // Register file load
    input  logic                rf_wr,
    input  slice_pkg::reg_idx_t rf_wr_addr,
    input  slice_pkg::word_t    rf_wr_data,

    // TLB load
    input  logic                tlb_wr,
    input  slice_pkg::tlb_idx_t tlb_wr_idx,
    input  slice_pkg::vpn_t     tlb_wr_vp,
    input  slice_pkg::pfn_t     tlb_wr_pf,
    input  logic                tlb_wr_valid,
    input  logic                tlb_wr_rw,

    // Micro-op in
    input  logic                in_valid,
    input  slice_pkg::word_t    in_eip,
    input  slice_pkg::alu_op_e  in_aluk,
    input  slice_pkg::reg_idx_t in_base_reg,
    input  slice_pkg::reg_idx_t in_src_reg,
    input  slice_pkg::word_t    in_disp,
    input  logic                in_mem_wr,
    output logic                in_credit,

    // Result out
    output logic                out_valid,
    output slice_pkg::word_t    out_eip,
    output slice_pkg::word_t    out_result,
    output slice_pkg::word_t    out_phys_addr,
    output slice_pkg::fault_e   out_fault,
    input  logic                out_credit
);

    ag_if   ag_i ();
    xlat_if mem_q ();
    xlat_if q_ex ();

    logic pop;

    //////////////////////////////////////////////////////////////////////
    // RrAg -> MEM -> queue -> EX
    //////////////////////////////////////////////////////////////////////

    rrag_stage rrag_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rf_wr      (rf_wr),
        .rf_wr_addr (rf_wr_addr),
        .rf_wr_data (rf_wr_data),
        .in_valid   (in_valid),
        .in_eip     (in_eip),
        .in_aluk    (in_aluk),
        .in_base_reg(in_base_reg),
        .in_src_reg (in_src_reg),
        .in_disp    (in_disp),
        .in_mem_wr  (in_mem_wr),
        .ag         (ag_i.src)
    );

    mem_tlb_stage mem_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .tlb_wr      (tlb_wr),
        .tlb_wr_idx  (tlb_wr_idx),
        .tlb_wr_vp   (tlb_wr_vp),
        .tlb_wr_pf   (tlb_wr_pf),
        .tlb_wr_valid(tlb_wr_valid),
        .tlb_wr_rw   (tlb_wr_rw),
        .ag          (ag_i.dst),
        .mem_q       (mem_q.src)
    );

    queued_latch #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_q    (mem_q.dst),
        .q_ex     (q_ex.src),
        .pop      (pop),
        .in_credit(in_credit)
    );

    execute_stage #(
        .OUT_CREDITS(OUT_CREDITS)
    ) ex_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .q_ex         (q_ex.dst),
        .pop          (pop),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_eip      (out_eip),
        .out_result   (out_result),
        .out_phys_addr(out_phys_addr),
        .out_fault    (out_fault)
    );

endmodule

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// Failure handling
//////////////////////////////////////////////////////////////////////

// Ends the run on the first failure
task automatic stop_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at %0t", $time);
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

// Addresses, results, eip and single flags widened to a word
task automatic check_word(input string field, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("ERR %0t: %s is %08h, expected %08h", $time, field, got, exp);
        stop_run();
    end
endtask

task automatic check_fault(input string field, input fault_e got, input fault_e exp);
    if (got !== exp) begin
        $display("ERR %0t: %s is %s, expected %s", $time, field, got.name(), exp.name());
        stop_run();
    end
endtask

`endif

//--- bench/tb_core_slice.sv
`timescale 1ns/1ps

module tb_core_slice;
    import slice_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int OUT_CREDITS = 4;
    localparam int NUM_OPS = 300;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 200;
    localparam int HIT_PERCENT = 80;
    localparam int unsigned SEED = 32'h862eaa81;

    typedef struct packed {
        word_t  eip;
        word_t  result;
        word_t  phys_addr;
        fault_e fault;
    } expect_t;

    logic     clk;
    logic     rst_n;
    logic     rf_wr;
    reg_idx_t rf_wr_addr;
    word_t    rf_wr_data;
    logic     tlb_wr;
    tlb_idx_t tlb_wr_idx;
    vpn_t     tlb_wr_vp;
    pfn_t     tlb_wr_pf;
    logic     tlb_wr_valid;
    logic     tlb_wr_rw;
    logic     in_valid;
    word_t    in_eip;
    alu_op_e  in_aluk;
    reg_idx_t in_base_reg;
    reg_idx_t in_src_reg;
    word_t    in_disp;
    logic     in_mem_wr;
    logic     in_credit;
    logic     out_valid;
    word_t    out_eip;
    word_t    out_result;
    word_t    out_phys_addr;
    fault_e   out_fault;
    logic     out_credit;

    // Reference copies of the loaded tables
    word_t                  rf_m [REG_COUNT];
    vpn_t                   vp_m [TLB_ENTRIES];
    pfn_t                   pf_m [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] rw_m;
    expect_t                exp_q [$];

    int sent = 0;
    int credits_back = 0;
    int got_count = 0;
    int issued = 0;
    int cycles = 0;

    `include "tb_checks.svh"

    core_slice_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SHL: return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    // Every model entry is valid and the first match wins
    function automatic void translate(input word_t lin, input logic wr,
                                      output word_t pa, output fault_e f);
        bit found;

        found = 1'b0;
        pa = '0;
        f = FAULT_TLB_MISS;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!found && vp_m[i] == lin[WORD_BITS-1:PAGE_OFFSET_BITS]) begin
                found = 1'b1;
                pa = {pf_m[i], lin[PAGE_OFFSET_BITS-1:0]};
                f = (wr && !rw_m[i]) ? FAULT_WRITE_PROT : FAULT_NONE;
            end
        end
    endfunction

    function automatic vpn_t free_vpn();
        vpn_t v;
        bit   taken;

        do begin
            v = vpn_t'($urandom());
            taken = 1'b0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (vp_m[i] == v) taken = 1'b1;
            end
        end while (taken);
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic load_tables();
        for (int i = 0; i < REG_COUNT; i++) begin
            rf_m[i] = $urandom();
            rf_wr = 1'b1;
            rf_wr_addr = reg_idx_t'(i);
            rf_wr_data = rf_m[i];
            next_cycle();
        end
        rf_wr = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            // Index in the low bits keeps the pages distinct
            vp_m[i] = {17'($urandom()), tlb_idx_t'(i)};
            pf_m[i] = pfn_t'($urandom());
            rw_m[i] = 1'($urandom_range(0, 1));
            tlb_wr = 1'b1;
            tlb_wr_idx = tlb_idx_t'(i);
            tlb_wr_vp = vp_m[i];
            tlb_wr_pf = pf_m[i];
            tlb_wr_valid = 1'b1;
            tlb_wr_rw = rw_m[i];
            next_cycle();
        end
        tlb_wr = 1'b0;
    endtask

    task automatic send_op(input int n);
        reg_idx_t base;
        vpn_t     vpn;
        word_t    lin;
        word_t    pa;
        fault_e   f;
        expect_t  e;

        base = reg_idx_t'($urandom_range(0, REG_COUNT - 1));
        if ($urandom_range(0, 99) < HIT_PERCENT) begin
            vpn = vp_m[tlb_idx_t'($urandom_range(0, TLB_ENTRIES - 1))];
        end else begin
            vpn = free_vpn();
        end
        lin = {vpn, PAGE_OFFSET_BITS'($urandom())};
        in_valid = 1'b1;
        in_eip = 32'h0010_0000 + (word_t'(n) << 2);
        in_aluk = alu_op_e'($urandom_range(0, 5));
        in_base_reg = base;
        in_src_reg = reg_idx_t'($urandom_range(0, REG_COUNT - 1));
        in_disp = lin - rf_m[base];
        in_mem_wr = 1'($urandom_range(0, 1));
        translate(lin, in_mem_wr, pa, f);
        e.eip = in_eip;
        e.phys_addr = pa;
        e.fault = f;
        e.result = (f == FAULT_NONE) ? alu_model(in_aluk, rf_m[in_src_reg], in_disp) : '0;
        exp_q.push_back(e);
        sent++;
        next_cycle();
        in_valid = 1'b0;
    endtask

    initial begin : stimulus
        void'($urandom(SEED));
        rst_n = 1'b0;
        rf_wr = 1'b0;
        rf_wr_addr = '0;
        rf_wr_data = '0;
        tlb_wr = 1'b0;
        tlb_wr_idx = '0;
        tlb_wr_vp = '0;
        tlb_wr_pf = '0;
        tlb_wr_valid = 1'b0;
        tlb_wr_rw = 1'b0;
        in_valid = 1'b0;
        in_eip = '0;
        in_aluk = ALU_ADD;
        in_base_reg = '0;
        in_src_reg = '0;
        in_disp = '0;
        in_mem_wr = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        load_tables();
        repeat (4) next_cycle();
        for (int n = 0; n < NUM_OPS; n++) begin
            // Wait for an input credit and idle now and then
            while ((sent - credits_back) >= QUEUE_DEPTH || $urandom_range(0, 7) == 0) begin
                next_cycle();
            end
            send_op(n);
        end
        while (got_count < NUM_OPS) next_cycle();
        repeat (8) next_cycle();
        if (credits_back != NUM_OPS) begin
            $display("Run ended with %0d input credits returned for %0d micro-ops",
                     credits_back, NUM_OPS);
            stop_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    // Consumer holds credits back for part of every 256 cycles
    initial begin : credit_return
        out_credit = 1'b0;
        @(posedge rst_n);
        forever begin
            next_cycle();
            out_credit = 1'b0;
            if ((cycles % 256) >= 96 && got_count > issued && $urandom_range(0, 99) < 30) begin
                out_credit = 1'b1;
                issued++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : monitor
        expect_t e;

        if (rst_n) begin
            if (sent == 0) begin
                check_word("out_valid before first micro-op", word_t'(out_valid), '0);
                check_word("in_credit before first micro-op", word_t'(in_credit), '0);
            end
            if (in_credit) begin
                credits_back++;
                if (credits_back > sent) begin
                    $display("Input credits returned (%0d) exceed micro-ops sent (%0d)",
                             credits_back, sent);
                    stop_run();
                end
            end
            if (out_valid) begin
                got_count++;
                if (got_count > OUT_CREDITS + issued) begin
                    $display("Result %0d came out without an output credit", got_count);
                    stop_run();
                end else if (exp_q.size() == 0) begin
                    $display("A result came out with no micro-op in flight");
                    stop_run();
                end else begin
                    e = exp_q.pop_front();
                    check_word("eip", out_eip, e.eip);
                    check_word("result", out_result, e.result);
                    check_word("phys_addr", out_phys_addr, e.phys_addr);
                    check_fault("fault", out_fault, e.fault);
                end
            end
        end
    end

endmodule

//--- tb.f
+incdir+include
hdl/slice_pkg.sv
hdl/stage_ifs.sv
hdl/rrag_stage.sv
hdl/mem_tlb_stage.sv
hdl/queued_latch.sv
hdl/execute_stage.sv
hdl/core_slice_top.sv
bench/tb_core_slice.sv

//--- Makefile
# Verilator build and run of the core slice testbench

VERILATOR ?= verilator
TOP       ?= tb_core_slice
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit code
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
